// ==== all.f ====
+incdir+include
logic/sdram_pkg.sv
logic/request_capture.sv
logic/command_issue.sv
logic/bank_tracker.sv
logic/sdram_scheduler.sv
bench/tb_sdram_scheduler.sv

// ==== include/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ------------------------------
// Open-page model
// ------------------------------

// Follows ACTV and PRCH the way the bank tracker does
function automatic void model_apply
(
  input  logic [sdram_pkg::CMD_W-1:0]  cmd,
  input  sdram_pkg::req_addr_u         req,
  inout  logic                         page_active,
  inout  logic [sdram_pkg::PAGE_W-1:0] open_page
);
  if (cmd == sdram_pkg::cmd_actv)
  begin
    page_active = 1'b1;
    open_page   = req.paged.page;
  end
  else if (cmd == sdram_pkg::cmd_prch)
    page_active = 1'b0;
endfunction

// ------------------------------
// Next expected command
// ------------------------------
// Bank only matters for ACTV, READ and WRTE
// ARSR carries no defined address
function automatic void next_expected
(
  input  logic [sdram_pkg::PAGE_W-1:0] open_page,
  input  logic                         page_active,
  input  logic                         refresh_pending,
  input  sdram_pkg::req_addr_u         req,
  input  logic                         req_we,
  output logic [sdram_pkg::CMD_W-1:0]  cmd,
  output logic [sdram_pkg::ROW_W-1:0]  addr,
  output logic [sdram_pkg::BANK_W-1:0] bank
);
  logic                        hit;
  logic [sdram_pkg::ROW_W-1:0] col_word;

  hit      = page_active && !refresh_pending && (req.paged.page == open_page);
  col_word = req.fields.col;
  bank     = open_page[sdram_pkg::BANK_W-1:0];
  addr     = 'x;

  if (hit)
  begin
    cmd  = req_we ? sdram_pkg::cmd_wrte : sdram_pkg::cmd_read;
    addr = col_word << 1;  // Column starts at A1
    bank = req.fields.bank;
  end
  else if (page_active)
  begin
    cmd  = sdram_pkg::cmd_prch;
    addr = sdram_pkg::PRCH_ALL_ADDR;
  end
  else if (refresh_pending)
    cmd = sdram_pkg::cmd_arsr;
  else
  begin
    cmd  = sdram_pkg::cmd_actv;
    addr = req.fields.row;
    bank = req.fields.bank;
  end
endfunction

`endif

// ==== bench/tb_sdram_scheduler.sv ====
module tb_sdram_scheduler;
  timeunit 1ns;
  timeprecision 100ps;

  import sdram_pkg::*;

  logic              INPUT_CLK = 1'b0;
  logic              RST;
  logic              refresh_strobe;
  req_addr_u         rand_address;
  logic              rand_we;
  logic              rand_request;
  req_addr_u         bulk_address;
  logic              bulk_we;
  logic              bulk_request;
  logic              rand_grant;
  logic              bulk_grant;
  logic [CMD_W-1:0]  command;
  logic [ROW_W-1:0]  address;
  logic [BANK_W-1:0] bank;

  logic [PAGE_W-1:0] model_page;
  logic              model_active;
  logic              model_ack;     // Strobe value at the last ARSR
  string             test_name;

`include "tb_ref_model.svh"

  sdram_scheduler UUT (.*);

  always #10 INPUT_CLK = ~INPUT_CLK;  // 20 ns period

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      stop_with_failure($sformatf("ERROR %s %s: expected %0h, actual %0h",
                                  test_name, what, expected, actual));
  endtask

  function automatic req_addr_u make_addr(input logic [ROW_W-1:0] row,
                                          input logic [BANK_W-1:0] bnk,
                                          input logic [COL_W-1:0] col);
    req_addr_u a;
    a.fields.row  = row;
    a.fields.bank = bnk;
    a.fields.col  = col;
    return a;
  endfunction

  task automatic raise_request(input logic use_bulk, input req_addr_u addr, input logic we);
    if (use_bulk)
    begin
      bulk_address <= addr;
      bulk_we      <= we;
      bulk_request <= 1'b1;
    end
    else
    begin
      rand_address <= addr;
      rand_we      <= we;
      rand_request <= 1'b1;
    end
  endtask

  // Request stays up until its grant pulse
  task automatic wait_grant(input logic use_bulk);
    do
      @(negedge INPUT_CLK);
    while ((use_bulk ? bulk_grant : rand_grant) !== 1'b1);
    @(posedge INPUT_CLK);
    if (use_bulk)
      bulk_request <= 1'b0;
    else
      rand_request <= 1'b0;
  endtask

  task automatic access(input logic use_bulk, input req_addr_u addr, input logic we);
    @(posedge INPUT_CLK);
    raise_request(use_bulk, addr, we);
    wait_grant(use_bulk);
  endtask

  task automatic refresh_cycle();
    @(posedge INPUT_CLK);
    refresh_strobe <= !refresh_strobe;  // One toggle, one refresh
    @(posedge INPUT_CLK);
    while (model_ack !== refresh_strobe)
      @(posedge INPUT_CLK);
  endtask

  // ------------------------------
  // Compare process
  // ------------------------------
  always @(negedge INPUT_CLK)
  begin : compare
    logic              use_bulk;
    logic              refresh_pend;
    req_addr_u         req;
    logic              req_we;
    logic [CMD_W-1:0]  exp_cmd;
    logic [ROW_W-1:0]  exp_addr;
    logic [BANK_W-1:0] exp_bank;

    use_bulk     = bulk_request;  // Bulk wins
    req          = use_bulk ? bulk_address : rand_address;
    req_we       = use_bulk ? bulk_we : rand_we;
    refresh_pend = refresh_strobe ^ model_ack;

    if (RST)
    begin
      if (command === cmd_noop)
        check_value("grants on NOOP", 2'b00, {bulk_grant, rand_grant});
      else
      begin
        if (!rand_request && !bulk_request && !refresh_pend)
          stop_with_failure("A command was issued with no request or refresh pending");
        next_expected(model_page, model_active, refresh_pend, req, req_we,
                      exp_cmd, exp_addr, exp_bank);
        check_value("command", exp_cmd, command);
        if (exp_cmd != cmd_arsr)
          check_value("address", exp_addr, address);
        if (exp_cmd == cmd_read || exp_cmd == cmd_wrte)
          check_value("grants", use_bulk ? 2'b10 : 2'b01, {bulk_grant, rand_grant});
        else
          check_value("grants", 2'b00, {bulk_grant, rand_grant});
        if (exp_cmd != cmd_prch && exp_cmd != cmd_arsr)
          check_value("bank", exp_bank, bank);
        if (command == cmd_arsr)
          model_ack = refresh_strobe;
        model_apply(command, req, model_active, model_page);
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial
  begin
    req_addr_u addr;

    void'($urandom(81851));
    test_name      = "reset";
    model_page     = '0;
    model_active   = 1'b0;
    model_ack      = 1'b0;
    RST            <= 1'b0;
    refresh_strobe <= 1'b0;
    rand_address   <= '0;
    rand_we        <= 1'b0;
    rand_request   <= 1'b0;
    bulk_address   <= '0;
    bulk_we        <= 1'b0;
    bulk_request   <= 1'b0;
    repeat (5) @(posedge INPUT_CLK);
    RST <= 1'b1;

    test_name = "quiet";
    repeat (50) @(posedge INPUT_CLK);

    test_name = "closed_page";
    access(1'b0, make_addr(14'h0123, 3'd2, 9'h045), 1'b0);

    test_name = "page_hit";
    access(1'b0, make_addr(14'h0123, 3'd2, 9'h1a0), 1'b1);
    access(1'b0, make_addr(14'h0123, 3'd2, 9'h001), 1'b1);  // Same direction
    access(1'b0, make_addr(14'h0123, 3'd2, 9'h0ff), 1'b0);

    test_name = "page_miss";
    access(1'b0, make_addr(14'h2abc, 3'd5, 9'h010), 1'b0);

    test_name = "refresh";
    refresh_cycle();
    access(1'b0, make_addr(14'h2abc, 3'd5, 9'h011), 1'b1);

    test_name = "priority";
    @(posedge INPUT_CLK);
    raise_request(1'b1, make_addr(14'h0777, 3'd1, 9'h022), 1'b1);
    raise_request(1'b0, make_addr(14'h1555, 3'd6, 9'h033), 1'b0);
    wait_grant(1'b1);
    wait_grant(1'b0);

    test_name = "random";
    for (int i = 0; i < 40; i++)
    begin
      if ($urandom_range(0, 7) == 0)
        refresh_cycle();
      // Few pages, so hits and misses both show up
      addr = make_addr($urandom_range(0, 1) ? 14'h0123 : 14'h3e01,
                       $urandom_range(0, 1), $urandom_range(0, 511));
      access($urandom_range(0, 1), addr, $urandom_range(0, 1));
      repeat ($urandom_range(0, 4)) @(posedge INPUT_CLK);
    end

    test_name = "done";
    repeat (10) @(posedge INPUT_CLK);
    $display("Test OK");
    $finish;
  end

  // Reset, quiet window, then 200 cycles per request or refresh
  initial
  begin
    repeat (5 + 50 + 200 * (9 + 2 * 40)) @(posedge INPUT_CLK);
    $display("Watchdog expired before all tests completed");
    $display("Test FAILED");
    $fatal(1, "Timeout");
  end

endmodule

// ==== logic/bank_tracker.sv ====
module bank_tracker
(
  input  logic                        INPUT_CLK,
  input  logic                        RST,
  input  logic [sdram_pkg::CMD_W-1:0] issued_command,
  input  logic                        refresh_strobe,
  output logic                        page_active,
  output logic                        last_was_write,
  output logic                        refresh_ack,
  output logic                        change_ok,
  output logic                        actv_settled
);
  import sdram_pkg::*;

  logic [CNT_W-1:0]            cnt;
  logic [$bits(ACTV_WAIT)-1:0] actv_cnt;
  logic                        extra_pass;  // Long wait after refresh
  logic                        cmd_valid;
  logic                        in_window;

  assign cmd_valid = issued_command != cmd_noop;

  // Precharge after a write needs the later window
  always_comb
  begin
    if (page_active && last_was_write)
      in_window = (cnt == CNT_DELAY_LO) || (cnt == CNT_DELAY_HI);
    else
      in_window = (cnt == CNT_READY_LO) || (cnt == CNT_READY_HI);
  end

  assign change_ok    = in_window && !extra_pass;
  assign actv_settled = actv_cnt == ACTV_WAIT;

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      page_active    <= 1'b0;
      last_was_write <= 1'b0;
      refresh_ack    <= 1'b0;
      extra_pass     <= 1'b0;
      cnt            <= CNT_AFTER_NOOP;  // Top of the ready window
      actv_cnt       <= ACTV_WAIT;
    end
    else if (cmd_valid)
    begin
      if (issued_command == cmd_actv)
        page_active <= 1'b1;
      else if (issued_command == cmd_prch)
        page_active <= 1'b0;

      last_was_write <= issued_command == cmd_wrte;

      if (issued_command == cmd_arsr)
      begin
        refresh_ack <= refresh_strobe;  // Clears refresh_due
        extra_pass  <= 1'b1;
      end

      if (issued_command == cmd_actv)
        actv_cnt <= '0;
      else if (!actv_settled)
        actv_cnt <= actv_cnt + 1'b1;

      case (issued_command)
        cmd_arsr: cnt <= CNT_AFTER_ARSR;
        cmd_actv: cnt <= CNT_AFTER_ACTV;
        default:  cnt <= CNT_AFTER_OTHER;
      endcase
    end
    else
    begin
      if (!change_ok)
        cnt <= cnt + 1'b1;          // Wraps once during the extra pass

      if (cnt == '0)
        extra_pass <= 1'b0;

      if (!actv_settled)
        actv_cnt <= actv_cnt + 1'b1;
    end
  end

endmodule

// ==== logic/command_issue.sv ====
module command_issue
(
  input  logic                         INPUT_CLK,
  input  logic                         RST,
  input  logic                         rand_req_q,
  input  logic                         bulk_req_q,
  input  sdram_pkg::req_addr_u         bulk_address_q,
  input  sdram_pkg::req_addr_u         rand_address_q,
  input  logic                         req_is_write,
  input  logic                         refresh_due,
  input  logic                         hit_rand,
  input  logic                         hit_bulk,
  input  logic                         hit_any,
  input  logic                         change_ok,
  input  logic                         actv_settled,
  input  logic                         page_active,
  input  logic                         last_was_write,
  output logic [sdram_pkg::CMD_W-1:0]  command,
  output logic [sdram_pkg::ROW_W-1:0]  address,
  output logic [sdram_pkg::BANK_W-1:0] bank,
  output logic                         rand_grant,
  output logic                         bulk_grant,
  output logic [sdram_pkg::CMD_W-1:0]  issued_command,
  output logic [sdram_pkg::PAGE_W-1:0] open_page
);
  import sdram_pkg::*;

  logic             stroke;     // Low on the cycle after an issue
  logic             rw_issued;  // Last issue was READ/WRTE
  logic             grant_d;    // Captured request still shows the granted access
  logic             on_page;
  logic             want_any;
  logic             issue;
  logic             load_page;
  req_addr_u        winner;
  logic [CMD_W-1:0] next_cmd;
  logic [ROW_W-1:0] next_address;

  assign winner = bulk_req_q ? bulk_address_q : rand_address_q;  // Bulk first

  // ------------------------------
  // Issue decision
  // ------------------------------
  // Back-to-back accesses of one direction skip the spacing counter
  assign on_page  = rw_issued && hit_any && (req_is_write == last_was_write);
  assign want_any = rand_req_q || bulk_req_q || refresh_due;

  always_comb
  begin
    if (hit_any)
      next_cmd = req_is_write ? cmd_wrte : cmd_read;
    else if (page_active)
      next_cmd = actv_settled ? cmd_prch : cmd_noop;  // Wait out tRAS
    else if (refresh_due)
      next_cmd = cmd_arsr;
    else
      next_cmd = cmd_actv;
  end

  always_comb
  begin
    if (hit_any)
      next_address = {{(ROW_W-COL_W-1){1'b0}}, winner.fields.col, 1'b0};
    else if (page_active || refresh_due)
      next_address = PRCH_ALL_ADDR;
    else
      next_address = winner.fields.row;
  end

  assign issue = stroke && !grant_d
                 && (on_page || (change_ok && want_any && (next_cmd != cmd_noop)));

  assign load_page = issue && (hit_any || (next_cmd == cmd_actv));

  assign issued_command = command;

  // ------------------------------
  // Command and grant registers
  // ------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      command    <= cmd_noop;
      rand_grant <= 1'b0;
      bulk_grant <= 1'b0;
      stroke     <= 1'b1;
      rw_issued  <= 1'b0;
      grant_d    <= 1'b0;
    end
    else
    begin
      stroke  <= !issue;
      grant_d <= rand_grant || bulk_grant;

      if (issue)
      begin
        command   <= next_cmd;
        rw_issued <= hit_any;
      end
      else
        command <= cmd_noop;

      // Same edge as the READ/WRTE
      bulk_grant <= issue && hit_any && hit_bulk;
      rand_grant <= issue && hit_any && hit_rand && !hit_bulk;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issue)
      address <= next_address;

    if (load_page)
    begin
      open_page <= winner.paged.page;
      bank      <= winner.fields.bank;
    end
  end

endmodule

// ==== logic/request_capture.sv ====
module request_capture
(
  input  logic                         INPUT_CLK,
  input  logic                         RST,
  input  logic                         refresh_strobe,
  input  sdram_pkg::req_addr_u         rand_address,
  input  logic                         rand_we,
  input  logic                         rand_request,
  input  sdram_pkg::req_addr_u         bulk_address,
  input  logic                         bulk_we,
  input  logic                         bulk_request,
  input  logic [sdram_pkg::PAGE_W-1:0] open_page,
  input  logic                         page_active,
  input  logic                         refresh_ack,
  output logic                         rand_req_q,
  output logic                         bulk_req_q,
  output sdram_pkg::req_addr_u         bulk_address_q,
  output sdram_pkg::req_addr_u         rand_address_q,
  output logic                         req_is_write,
  output logic                         refresh_due,
  output logic                         hit_rand,
  output logic                         hit_bulk,
  output logic                         hit_any
);
  import sdram_pkg::*;

  logic page_usable;
  logic hit_rand_w;
  logic hit_bulk_w;
  logic hit_any_w;

  // No hits while a refresh waits, so the page gets closed
  assign page_usable = page_active && !refresh_due;

  assign hit_rand_w = rand_request && page_usable
                      && (rand_address.paged.page == open_page);
  assign hit_bulk_w = bulk_request && page_usable
                      && (bulk_address.paged.page == open_page);

  // Hit of the port that has priority
  assign hit_any_w = bulk_request ? hit_bulk_w : hit_rand_w;

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      rand_req_q  <= 1'b0;
      bulk_req_q  <= 1'b0;
      refresh_due <= 1'b0;
      hit_rand    <= 1'b0;
      hit_bulk    <= 1'b0;
      hit_any     <= 1'b0;
    end
    else
    begin
      rand_req_q  <= rand_request;
      bulk_req_q  <= bulk_request;
      refresh_due <= refresh_ack ^ refresh_strobe;  // Strobe toggled, not yet served
      hit_rand    <= hit_rand_w;
      hit_bulk    <= hit_bulk_w;
      hit_any     <= hit_any_w;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    rand_address_q <= rand_address;
    bulk_address_q <= bulk_address;
    req_is_write   <= bulk_request ? bulk_we : rand_we;
  end

endmodule

// ==== logic/sdram_pkg.sv ====
package sdram_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int CMD_W  = 3;
  localparam int ROW_W  = 14;
  localparam int BANK_W = 3;
  localparam int PAGE_W = ROW_W + BANK_W;   // Row and bank together
  localparam int ADDR_W = 26;
  localparam int COL_W  = ADDR_W - PAGE_W;  // 9 column bits
  localparam int CNT_W  = 4;

  // ------------------------------
  // SDRAM command codes
  // ------------------------------
  // Encoded as {RAS#, CAS#, WE#}
  localparam logic [CMD_W-1:0] cmd_noop = 3'b111;
  localparam logic [CMD_W-1:0] cmd_actv = 3'b011;  // Row open
  localparam logic [CMD_W-1:0] cmd_read = 3'b101;
  localparam logic [CMD_W-1:0] cmd_wrte = 3'b100;
  localparam logic [CMD_W-1:0] cmd_prch = 3'b010;  // Row close
  localparam logic [CMD_W-1:0] cmd_arsr = 3'b001;  // Auto refresh

  localparam logic [ROW_W-1:0] PRCH_ALL_ADDR = 14'h0400;  // A10 selects all banks

  // ------------------------------
  // Command spacing
  // ------------------------------
  // Counter is reloaded after each command and counts up into a window
  localparam logic [CNT_W-1:0] CNT_AFTER_ARSR  = 4'd3;
  localparam logic [CNT_W-1:0] CNT_AFTER_ACTV  = 4'd12;
  localparam logic [CNT_W-1:0] CNT_AFTER_NOOP  = 4'd14;
  localparam logic [CNT_W-1:0] CNT_AFTER_OTHER = 4'd11;

  localparam logic [CNT_W-1:0] CNT_READY_LO = 4'd13;
  localparam logic [CNT_W-1:0] CNT_READY_HI = 4'd14;

  // Write recovery before a precharge
  localparam logic [CNT_W-1:0] CNT_DELAY_LO = 4'd14;
  localparam logic [CNT_W-1:0] CNT_DELAY_HI = 4'd15;

  localparam logic [2:0] ACTV_WAIT = 3'd4;  // ACTV to PRCH

  // ------------------------------
  // Request address
  // ------------------------------
  typedef union packed {
    struct packed {
      logic [ROW_W-1:0]  row;
      logic [BANK_W-1:0] bank;
      logic [COL_W-1:0]  col;
    } fields;
    struct packed {
      logic [PAGE_W-1:0] page;   // Compared against the open page
      logic [COL_W-1:0]  col;
    } paged;
  } req_addr_u;

endpackage

// ==== logic/sdram_scheduler.sv ====
module sdram_scheduler
(
  input  logic                         INPUT_CLK,
  input  logic                         RST,
  input  logic                         refresh_strobe,
  input  sdram_pkg::req_addr_u         rand_address,
  input  logic                         rand_we,
  input  logic                         rand_request,
  input  sdram_pkg::req_addr_u         bulk_address,
  input  logic                         bulk_we,
  input  logic                         bulk_request,
  output logic                         rand_grant,
  output logic                         bulk_grant,
  output logic [sdram_pkg::CMD_W-1:0]  command,
  output logic [sdram_pkg::ROW_W-1:0]  address,
  output logic [sdram_pkg::BANK_W-1:0] bank
);
  import sdram_pkg::*;

  logic              rand_req_q;
  logic              bulk_req_q;
  req_addr_u         rand_address_q;
  req_addr_u         bulk_address_q;
  logic              req_is_write;
  logic              refresh_due;
  logic              hit_rand;
  logic              hit_bulk;
  logic              hit_any;
  logic [PAGE_W-1:0] open_page;
  logic [CMD_W-1:0]  issued_command;
  logic              page_active;
  logic              last_was_write;
  logic              refresh_ack;
  logic              change_ok;
  logic              actv_settled;

  // ------------------------------
  // Request capture
  // ------------------------------
  request_capture u_capture
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_address   (rand_address),
    .rand_we        (rand_we),
    .rand_request   (rand_request),
    .bulk_address   (bulk_address),
    .bulk_we        (bulk_we),
    .bulk_request   (bulk_request),
    .open_page      (open_page),
    .page_active    (page_active),
    .refresh_ack    (refresh_ack),
    .rand_req_q     (rand_req_q),
    .bulk_req_q     (bulk_req_q),
    .bulk_address_q (bulk_address_q),
    .rand_address_q (rand_address_q),
    .req_is_write   (req_is_write),
    .refresh_due    (refresh_due),
    .hit_rand       (hit_rand),
    .hit_bulk       (hit_bulk),
    .hit_any        (hit_any)
  );

  // ------------------------------
  // Command issue
  // ------------------------------
  command_issue u_issue
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .rand_req_q     (rand_req_q),
    .bulk_req_q     (bulk_req_q),
    .bulk_address_q (bulk_address_q),
    .rand_address_q (rand_address_q),
    .req_is_write   (req_is_write),
    .refresh_due    (refresh_due),
    .hit_rand       (hit_rand),
    .hit_bulk       (hit_bulk),
    .hit_any        (hit_any),
    .change_ok      (change_ok),
    .actv_settled   (actv_settled),
    .page_active    (page_active),
    .last_was_write (last_was_write),
    .command        (command),
    .address        (address),
    .bank           (bank),
    .rand_grant     (rand_grant),
    .bulk_grant     (bulk_grant),
    .issued_command (issued_command),
    .open_page      (open_page)
  );

  bank_tracker u_tracker
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .issued_command (issued_command),
    .refresh_strobe (refresh_strobe),
    .page_active    (page_active),
    .last_was_write (last_was_write),
    .refresh_ack    (refresh_ack),
    .change_ok      (change_ok),
    .actv_settled   (actv_settled)
  );

endmodule
